/* hw/cfg_pkg.sv */
package cfg_pkg;

  localparam int DATA_W   = 64;                  // Stream data width
  localparam int STRB_W   = DATA_W / 8;          // Stream strobe width
  localparam int AXIL_W   = 32;                  // AXI-Lite addr/data width
  localparam int TAG_W    = 3;                   // Request tag bits actually used
  localparam int STATUS_W = 3;                   // Cpl status field

  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // TLP header codes for config requests
  localparam logic [2:0] FMT_NODATA  = 3'b000;   // 3DW, no data (CfgRd)
  localparam logic [2:0] FMT_DATA    = 3'b010;   // 3DW with data (CfgWr)
  localparam logic [3:0] TYPE_CFG_HI = 4'b0010;  // Type[4:1], Type[0] is cfg_type

  // Scaled down for simulation
  localparam logic [31:0] CPL_TIMEOUT_CYCLES = 32'd200;

  typedef enum logic {
    CFG_RD,
    CFG_WR
  } cfg_op_t;

  typedef enum logic [1:0] {
    IDLE,
    WAIT_CPL,
    RESPOND
  } req_state_t;

  // PCIe payload is big endian per dword, AXI side is little endian
  function automatic logic [AXIL_W-1:0] swap_bytes(input logic [AXIL_W-1:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

endpackage

/* hw/cfg_req_if.sv */
interface cfg_req_if import cfg_pkg::*; ();

  logic              start;   // One-cycle pulse, request accepted
  cfg_op_t           op;      // Read or write
  logic [AXIL_W-1:0] addr;    // Bus/dev/fn/reg packed address
  logic [AXIL_W-1:0] wdata;   // Write payload, zero on reads
  logic [3:0]        wstrb;   // Byte enables of the write

  modport front (
    output start, op, addr, wdata, wstrb
  );

  modport builder (
    input start, op, addr, wdata, wstrb
  );

endinterface

/* hw/cfg_axil_slave.sv */
module cfg_axil_slave import cfg_pkg::*; (
  input  logic                com_cclk,
  input  logic                com_sysrst,
  input  logic [AXIL_W-1:0]   s_axi_ctl_awaddr,
  input  logic                s_axi_ctl_awvalid,
  output logic                s_axi_ctl_awready,
  input  logic [AXIL_W-1:0]   s_axi_ctl_wdata,
  input  logic [3:0]          s_axi_ctl_wstrb,
  input  logic                s_axi_ctl_wvalid,
  output logic                s_axi_ctl_wready,
  output logic [1:0]          s_axi_ctl_bresp,
  output logic                s_axi_ctl_bvalid,
  input  logic                s_axi_ctl_bready,
  input  logic [AXIL_W-1:0]   s_axi_ctl_araddr,
  input  logic                s_axi_ctl_arvalid,
  output logic                s_axi_ctl_arready,
  output logic [AXIL_W-1:0]   s_axi_ctl_rdata,
  output logic [1:0]          s_axi_ctl_rresp,
  output logic                s_axi_ctl_rvalid,
  input  logic                s_axi_ctl_rready,
  cfg_req_if.front            req,
  input  logic                cpl_valid,      // Matching completion seen
  input  logic [STATUS_W-1:0] cpl_status_in,
  input  logic [AXIL_W-1:0]   cpl_data,
  input  logic                expired,        // Completion timeout
  output logic                resp_done,
  output logic [STATUS_W-1:0] cpl_status,
  output logic                cfg_timeout
);

  req_state_t state;
  logic       wr_accept;
  logic       rd_accept;
  logic       cpl_end;                         // Completion or timeout ends the wait

  // Writes win over reads when both arrive together
  assign wr_accept = (state == IDLE) && s_axi_ctl_awvalid && s_axi_ctl_wvalid;
  assign rd_accept = (state == IDLE) && !wr_accept && s_axi_ctl_arvalid;
  assign cpl_end   = (state == WAIT_CPL) && (cpl_valid || expired);
  assign resp_done = (s_axi_ctl_bvalid && s_axi_ctl_bready) ||
                     (s_axi_ctl_rvalid && s_axi_ctl_rready);

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      state             <= IDLE;
      s_axi_ctl_awready <= 1'b0;
      s_axi_ctl_wready  <= 1'b0;
      s_axi_ctl_arready <= 1'b0;
      s_axi_ctl_bvalid  <= 1'b0;
      s_axi_ctl_rvalid  <= 1'b0;
      req.start         <= 1'b0;
      cpl_status        <= '0;
      cfg_timeout       <= 1'b0;
    end else begin
      s_axi_ctl_awready <= wr_accept;          // Single-cycle ready pulses
      s_axi_ctl_wready  <= wr_accept;
      s_axi_ctl_arready <= rd_accept;
      req.start         <= wr_accept || rd_accept;
      case (state)
        IDLE: begin
          if (wr_accept || rd_accept) begin
            state <= WAIT_CPL;
          end
        end
        WAIT_CPL: begin
          if (cpl_end) begin
            state            <= RESPOND;
            s_axi_ctl_bvalid <= (req.op == CFG_WR);
            s_axi_ctl_rvalid <= (req.op == CFG_RD);
            cpl_status       <= cpl_valid ? cpl_status_in : '0;
            cfg_timeout      <= !cpl_valid;    // Real completion beats the timer
          end
        end
        RESPOND: begin
          if (resp_done) begin
            state            <= IDLE;
            s_axi_ctl_bvalid <= 1'b0;
            s_axi_ctl_rvalid <= 1'b0;
            cpl_status       <= '0;
            cfg_timeout      <= 1'b0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Request fields and response payload
  always_ff @(posedge com_cclk) begin
    if (wr_accept) begin
      req.op    <= CFG_WR;
      req.addr  <= s_axi_ctl_awaddr;
      req.wdata <= s_axi_ctl_wdata;
      req.wstrb <= s_axi_ctl_wstrb;
    end else if (rd_accept) begin
      req.op    <= CFG_RD;
      req.addr  <= s_axi_ctl_araddr;
      req.wdata <= '0;
      req.wstrb <= '0;
    end
    if (cpl_end) begin
      if (cpl_valid && (cpl_status_in == '0)) begin // Successful completion
        s_axi_ctl_bresp <= RESP_OKAY;
        s_axi_ctl_rresp <= RESP_OKAY;
      end else begin                           // UR, CRS, CA or timeout
        s_axi_ctl_bresp <= RESP_SLVERR;
        s_axi_ctl_rresp <= RESP_SLVERR;
      end
      s_axi_ctl_rdata <= cpl_valid ? cpl_data : '0;
    end
  end

  // Ready pulses and responses never overlap
  a_ready_excl: assert property (@(posedge com_cclk) disable iff (com_sysrst)
    $onehot0({s_axi_ctl_awready, s_axi_ctl_arready, s_axi_ctl_bvalid, s_axi_ctl_rvalid}));

  // A new request opens the wait, never with a response pending
  a_start_idle: assert property (@(posedge com_cclk) disable iff (com_sysrst)
    req.start |-> (state == WAIT_CPL) && !(s_axi_ctl_bvalid || s_axi_ctl_rvalid));

endmodule

/* hw/cfg_tlp_builder.sv */
module cfg_tlp_builder import cfg_pkg::*; (
  input  logic              com_cclk,
  input  logic              com_sysrst,
  cfg_req_if.builder        req,
  input  logic [15:0]       requester_id,
  input  logic              cfg_type,          // Type 0 or type 1 config
  output logic [DATA_W-1:0] s_axis_cfg_tdata,
  output logic              s_axis_cfg_tvalid,
  input  logic              s_axis_cfg_tready,
  output logic [STRB_W-1:0] s_axis_cfg_tstrb,
  output logic              s_axis_cfg_tlast,
  output logic [TAG_W-1:0]  cur_tag,
  output logic              tx_done
);

  cfg_op_t           op_q;                     // Held for beat 2
  logic [AXIL_W-1:0] addr_q;
  logic [AXIL_W-1:0] wdata_q;
  logic [TAG_W-1:0]  next_tag;
  logic [2:0]        fmt;
  logic [3:0]        first_be;
  logic [31:0]       hdr_dw0;
  logic [31:0]       hdr_dw1;
  logic [31:0]       hdr_dw2;
  logic [31:0]       payload;
  logic              beat_ok;

  assign next_tag = cur_tag + 1'b1;
  assign fmt      = (req.op == CFG_WR) ? FMT_DATA : FMT_NODATA;
  assign first_be = (req.op == CFG_WR) ? req.wstrb : 4'hF;

  // H0: fmt, type, TC/attr/TD/EP all zero, length 1DW
  assign hdr_dw0 = {fmt, TYPE_CFG_HI, cfg_type, 14'd0, 10'd1};
  // H1: requester, tag, last BE zero, first BE
  assign hdr_dw1 = {requester_id, 5'd0, next_tag, 4'd0, first_be};
  assign hdr_dw2 = {addr_q[27:20],             // Bus
                    addr_q[19:15],             // Device
                    addr_q[14:12],             // Function
                    4'd0,
                    addr_q[11:0]};             // Ext reg, reg, byte addr
  assign payload = (op_q == CFG_WR) ? swap_bytes(wdata_q) : '0;

  assign beat_ok = s_axis_cfg_tvalid && s_axis_cfg_tready;
  assign tx_done = beat_ok && s_axis_cfg_tlast;

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      s_axis_cfg_tvalid <= 1'b0;
      s_axis_cfg_tlast  <= 1'b0;
      s_axis_cfg_tstrb  <= '0;
      cur_tag           <= '0;
    end else if (req.start) begin              // Beat 1, header H0 H1
      s_axis_cfg_tvalid <= 1'b1;
      s_axis_cfg_tlast  <= 1'b0;
      s_axis_cfg_tstrb  <= '1;
      cur_tag           <= next_tag;
    end else if (beat_ok && !s_axis_cfg_tlast) begin // Beat 2, H2 and data
      s_axis_cfg_tlast <= 1'b1;
      if (op_q == CFG_WR) begin
        s_axis_cfg_tstrb <= '1;
      end else begin
        s_axis_cfg_tstrb <= {{(STRB_W / 2){1'b0}}, {(STRB_W / 2){1'b1}}};
      end
    end else if (beat_ok) begin                // TLP done
      s_axis_cfg_tvalid <= 1'b0;
      s_axis_cfg_tlast  <= 1'b0;
      s_axis_cfg_tstrb  <= '0;
    end
  end

  always_ff @(posedge com_cclk) begin
    if (req.start) begin
      s_axis_cfg_tdata <= {hdr_dw1, hdr_dw0};
      op_q             <= req.op;
      addr_q           <= req.addr;
      wdata_q          <= req.wdata;
    end else if (beat_ok && !s_axis_cfg_tlast) begin
      s_axis_cfg_tdata <= {payload, hdr_dw2};
    end
  end

  a_tdata_hold: assert property (@(posedge com_cclk) disable iff (com_sysrst)
    s_axis_cfg_tvalid && !s_axis_cfg_tready |=> $stable(s_axis_cfg_tdata));

endmodule

/* hw/cfg_cpl_parser.sv */
module cfg_cpl_parser import cfg_pkg::*; (
  input  logic                com_cclk,
  input  logic                com_sysrst,
  input  logic [DATA_W-1:0]   m_axis_cfg_tdata,
  input  logic                m_axis_cfg_tvalid,
  output logic                m_axis_cfg_tready,
  input  logic [STRB_W-1:0]   m_axis_cfg_tstrb,
  input  logic                m_axis_cfg_tlast,
  input  logic [TAG_W-1:0]    cur_tag,         // Tag of the pending request
  output logic                cpl_valid,
  output logic [STATUS_W-1:0] cpl_status,
  output logic [AXIL_W-1:0]   cpl_data
);

  logic             beat_ok;
  logic             in_pkt;                    // Beat 1 already taken
  logic [TAG_W-1:0] rx_tag;

  assign beat_ok = m_axis_cfg_tvalid && m_axis_cfg_tready;
  assign rx_tag  = m_axis_cfg_tdata[10:8];     // H2 tag, low bits

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      m_axis_cfg_tready <= 1'b0;
      in_pkt            <= 1'b0;
      cpl_valid         <= 1'b0;
    end else begin
      cpl_valid <= 1'b0;
      if (m_axis_cfg_tvalid) begin
        m_axis_cfg_tready <= 1'b1;
      end
      if (beat_ok && m_axis_cfg_tlast) begin   // Drop ready after last beat
        m_axis_cfg_tready <= 1'b0;
      end
      if (beat_ok) begin
        in_pkt <= !m_axis_cfg_tlast;
        // Stale tags are swallowed here
        if (in_pkt) begin
          cpl_valid <= m_axis_cfg_tlast && (rx_tag == cur_tag);
        end
      end
    end
  end

  always_ff @(posedge com_cclk) begin
    if (beat_ok && !in_pkt) begin
      cpl_status <= m_axis_cfg_tdata[47:45];   // H1[15:13]
    end
    if (beat_ok && in_pkt) begin
      // CplD fills the whole beat, plain Cpl only H2
      if (m_axis_cfg_tstrb == '1) begin
        cpl_data <= swap_bytes(m_axis_cfg_tdata[63:32]);
      end else begin
        cpl_data <= '0;
      end
    end
  end

endmodule

/* hw/cfg_cpl_timer.sv */
module cfg_cpl_timer import cfg_pkg::*; (
  input  logic com_cclk,
  input  logic com_sysrst,
  input  logic tx_done,                        // Last request beat sent
  input  logic resp_done,                      // AXI-Lite response taken
  output logic expired
);

  logic        running;
  logic [31:0] count;

  always_ff @(posedge com_cclk) begin
    if (com_sysrst) begin
      running <= 1'b0;
      count   <= '0;
      expired <= 1'b0;
    end else begin
      expired <= 1'b0;
      if (tx_done) begin                       // Restart on every request
        running <= 1'b1;
        count   <= 32'd1;
      end else if (resp_done) begin
        running <= 1'b0;
      end else if (running) begin
        count <= count + 32'd1;
        if (count == CPL_TIMEOUT_CYCLES - 32'd1) begin // Fire once and stop
          expired <= 1'b1;
          running <= 1'b0;
        end
      end
    end
  end

  // Expiry only ever follows a started request by the full timeout
  a_expire_running: assert property (@(posedge com_cclk) disable iff (com_sysrst)
    expired |-> $past(tx_done, CPL_TIMEOUT_CYCLES));

endmodule

/* hw/cfg_bridge_top.sv */
module cfg_bridge_top import cfg_pkg::*; (
  input  logic                com_cclk,
  input  logic                com_sysrst,
  input  logic [AXIL_W-1:0]   s_axi_ctl_awaddr,
  input  logic                s_axi_ctl_awvalid,
  output logic                s_axi_ctl_awready,
  input  logic [AXIL_W-1:0]   s_axi_ctl_wdata,
  input  logic [3:0]          s_axi_ctl_wstrb,
  input  logic                s_axi_ctl_wvalid,
  output logic                s_axi_ctl_wready,
  output logic [1:0]          s_axi_ctl_bresp,
  output logic                s_axi_ctl_bvalid,
  input  logic                s_axi_ctl_bready,
  input  logic [AXIL_W-1:0]   s_axi_ctl_araddr,
  input  logic                s_axi_ctl_arvalid,
  output logic                s_axi_ctl_arready,
  output logic [AXIL_W-1:0]   s_axi_ctl_rdata,
  output logic [1:0]          s_axi_ctl_rresp,
  output logic                s_axi_ctl_rvalid,
  input  logic                s_axi_ctl_rready,
  output logic [DATA_W-1:0]   s_axis_cfg_tdata,  // Requests out
  output logic                s_axis_cfg_tvalid,
  input  logic                s_axis_cfg_tready,
  output logic [STRB_W-1:0]   s_axis_cfg_tstrb,
  output logic                s_axis_cfg_tlast,
  input  logic [DATA_W-1:0]   m_axis_cfg_tdata,  // Completions in
  input  logic                m_axis_cfg_tvalid,
  output logic                m_axis_cfg_tready,
  input  logic [STRB_W-1:0]   m_axis_cfg_tstrb,
  input  logic                m_axis_cfg_tlast,
  input  logic [15:0]         requester_id,
  input  logic                cfg_type,
  output logic [STATUS_W-1:0] cpl_status,
  output logic                cfg_timeout
);

  logic [TAG_W-1:0]    cur_tag;
  logic                tx_done;
  logic                cpl_valid;
  logic [STATUS_W-1:0] rx_cpl_status;
  logic [AXIL_W-1:0]   cpl_data;
  logic                expired;
  logic                resp_done;

  cfg_req_if req_bus ();

  cfg_axil_slave u_axil_slave (
    .com_cclk          (com_cclk),
    .com_sysrst        (com_sysrst),
    .s_axi_ctl_awaddr  (s_axi_ctl_awaddr),
    .s_axi_ctl_awvalid (s_axi_ctl_awvalid),
    .s_axi_ctl_awready (s_axi_ctl_awready),
    .s_axi_ctl_wdata   (s_axi_ctl_wdata),
    .s_axi_ctl_wstrb   (s_axi_ctl_wstrb),
    .s_axi_ctl_wvalid  (s_axi_ctl_wvalid),
    .s_axi_ctl_wready  (s_axi_ctl_wready),
    .s_axi_ctl_bresp   (s_axi_ctl_bresp),
    .s_axi_ctl_bvalid  (s_axi_ctl_bvalid),
    .s_axi_ctl_bready  (s_axi_ctl_bready),
    .s_axi_ctl_araddr  (s_axi_ctl_araddr),
    .s_axi_ctl_arvalid (s_axi_ctl_arvalid),
    .s_axi_ctl_arready (s_axi_ctl_arready),
    .s_axi_ctl_rdata   (s_axi_ctl_rdata),
    .s_axi_ctl_rresp   (s_axi_ctl_rresp),
    .s_axi_ctl_rvalid  (s_axi_ctl_rvalid),
    .s_axi_ctl_rready  (s_axi_ctl_rready),
    .req               (req_bus),
    .cpl_valid         (cpl_valid),
    .cpl_status_in     (rx_cpl_status),
    .cpl_data          (cpl_data),
    .expired           (expired),
    .resp_done         (resp_done),
    .cpl_status        (cpl_status),
    .cfg_timeout       (cfg_timeout)
  );

  cfg_tlp_builder u_tlp_builder (
    .com_cclk          (com_cclk),
    .com_sysrst        (com_sysrst),
    .req               (req_bus),
    .requester_id      (requester_id),
    .cfg_type          (cfg_type),
    .s_axis_cfg_tdata  (s_axis_cfg_tdata),
    .s_axis_cfg_tvalid (s_axis_cfg_tvalid),
    .s_axis_cfg_tready (s_axis_cfg_tready),
    .s_axis_cfg_tstrb  (s_axis_cfg_tstrb),
    .s_axis_cfg_tlast  (s_axis_cfg_tlast),
    .cur_tag           (cur_tag),
    .tx_done           (tx_done)
  );

  cfg_cpl_parser u_cpl_parser (
    .com_cclk          (com_cclk),
    .com_sysrst        (com_sysrst),
    .m_axis_cfg_tdata  (m_axis_cfg_tdata),
    .m_axis_cfg_tvalid (m_axis_cfg_tvalid),
    .m_axis_cfg_tready (m_axis_cfg_tready),
    .m_axis_cfg_tstrb  (m_axis_cfg_tstrb),
    .m_axis_cfg_tlast  (m_axis_cfg_tlast),
    .cur_tag           (cur_tag),
    .cpl_valid         (cpl_valid),
    .cpl_status        (rx_cpl_status),
    .cpl_data          (cpl_data)
  );

  cfg_cpl_timer u_cpl_timer (
    .com_cclk   (com_cclk),
    .com_sysrst (com_sysrst),
    .tx_done    (tx_done),
    .resp_done  (resp_done),
    .expired    (expired)
  );

endmodule

/* bench/tb_cfg_bridge.sv */
module tb_cfg_bridge import cfg_pkg::*; ();

  localparam int MAX_TX = 32;                  // Stimulus table depth

  logic                com_cclk = 1'b0;
  logic                com_sysrst;
  logic [AXIL_W-1:0]   s_axi_ctl_awaddr;
  logic                s_axi_ctl_awvalid;
  logic                s_axi_ctl_awready;
  logic [AXIL_W-1:0]   s_axi_ctl_wdata;
  logic [3:0]          s_axi_ctl_wstrb;
  logic                s_axi_ctl_wvalid;
  logic                s_axi_ctl_wready;
  logic [1:0]          s_axi_ctl_bresp;
  logic                s_axi_ctl_bvalid;
  logic                s_axi_ctl_bready;
  logic [AXIL_W-1:0]   s_axi_ctl_araddr;
  logic                s_axi_ctl_arvalid;
  logic                s_axi_ctl_arready;
  logic [AXIL_W-1:0]   s_axi_ctl_rdata;
  logic [1:0]          s_axi_ctl_rresp;
  logic                s_axi_ctl_rvalid;
  logic                s_axi_ctl_rready;
  logic [DATA_W-1:0]   s_axis_cfg_tdata;
  logic                s_axis_cfg_tvalid;
  logic                s_axis_cfg_tready = 1'b0;
  logic [STRB_W-1:0]   s_axis_cfg_tstrb;
  logic                s_axis_cfg_tlast;
  logic [DATA_W-1:0]   m_axis_cfg_tdata;
  logic                m_axis_cfg_tvalid;
  logic                m_axis_cfg_tready;
  logic [STRB_W-1:0]   m_axis_cfg_tstrb;
  logic                m_axis_cfg_tlast;
  logic [15:0]         requester_id;
  logic                cfg_type;
  logic [STATUS_W-1:0] cpl_status;
  logic                cfg_timeout;

  // One row per transaction, columns as in the stimulus file
  logic [31:0] tx_op [MAX_TX];
  logic [31:0] tx_type [MAX_TX];
  logic [31:0] tx_addr [MAX_TX];
  logic [31:0] tx_wdata [MAX_TX];
  logic [31:0] tx_wstrb [MAX_TX];
  logic [31:0] tx_act [MAX_TX];                // 0 ok, 1 bad status, 2 stale tag, 3 none
  logic [31:0] tx_status [MAX_TX];
  logic [31:0] tx_data [MAX_TX];               // Wire-order payload
  logic [31:0] tx_resp [MAX_TX];
  logic [31:0] tx_rdata [MAX_TX];
  int          n_tx = 0;

  logic [DATA_W-1:0] beat_data [2];            // Captured request beats
  logic [STRB_W-1:0] beat_strb [2];
  logic              beat_last [2];
  logic [TAG_W-1:0]  last_tag;
  bit                have_tag = 1'b0;
  int                errors = 0;               // Main flow checks
  int                stream_errors = 0;        // Beat hold monitor
  int                request_errors = 0;       // Overlap monitor
  int                wd_limit;
  bit                load_ok;

  logic              stalled = 1'b0;
  logic [DATA_W-1:0] held_data;
  logic [STRB_W-1:0] held_strb;
  logic              held_last;
  bit                req_open = 1'b0;

  cfg_bridge_top dut (.*);

  always #4 com_cclk = ~com_cclk;

  // Random back-pressure on the request stream
  always @(posedge com_cclk) begin
    #1;
    s_axis_cfg_tready = ($urandom % 4) != 0;
  end

  task automatic report_error(input string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic load_stimulus();
    int    fd;
    int    cnt;
    int    rc;
    string line;
    fd      = $fopen("bench/cfg_stimulus.txt", "r");
    load_ok = (fd != 0);
    if (load_ok) begin
      while (!$feof(fd) && n_tx < MAX_TX) begin
        rc = $fgets(line, fd);
        if (rc > 1 && line[0] != "#") begin   // Skip comments and blank lines
          cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", tx_op[n_tx], tx_type[n_tx],
                        tx_addr[n_tx], tx_wdata[n_tx], tx_wstrb[n_tx], tx_act[n_tx],
                        tx_status[n_tx], tx_data[n_tx], tx_resp[n_tx], tx_rdata[n_tx]);
          if (cnt == 10) begin
            n_tx++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic present_request(input int i);
    if (tx_op[i][0]) begin                     // Write, AW and W together
      s_axi_ctl_awaddr  = tx_addr[i];
      s_axi_ctl_wdata   = tx_wdata[i];
      s_axi_ctl_wstrb   = tx_wstrb[i][3:0];
      s_axi_ctl_awvalid = 1'b1;
      s_axi_ctl_wvalid  = 1'b1;
    end else begin
      s_axi_ctl_araddr  = tx_addr[i];
      s_axi_ctl_arvalid = 1'b1;
    end
  endtask

  task automatic issue_request(input int i);
    present_request(i);
    if (tx_op[i][0]) begin
      do @(negedge com_cclk); while (!s_axi_ctl_awready);
      if (!s_axi_ctl_wready) report_error("wready not raised with awready");
    end else begin
      do @(negedge com_cclk); while (!s_axi_ctl_arready);
    end
    @(posedge com_cclk);
    #1;
    s_axi_ctl_awvalid = 1'b0;
    s_axi_ctl_wvalid  = 1'b0;
    s_axi_ctl_arvalid = 1'b0;
  endtask

  task automatic capture_beats();
    int k;
    k = 0;
    while (k < 2) begin
      @(negedge com_cclk);
      if (s_axis_cfg_tvalid && s_axis_cfg_tready) begin // Accepted at next edge
        beat_data[k] = s_axis_cfg_tdata;
        beat_strb[k] = s_axis_cfg_tstrb;
        beat_last[k] = s_axis_cfg_tlast;
        k++;
      end
    end
    @(posedge com_cclk);
    #1;
  endtask

  task automatic check_beats(input int i);
    logic             is_wr;
    logic [TAG_W-1:0] tag;
    logic [TAG_W-1:0] exp_tag;
    logic [31:0]      a;
    is_wr   = tx_op[i][0];
    a       = tx_addr[i];
    tag     = beat_data[0][42:40];
    exp_tag = last_tag + 3'd1;
    expect_eq("beat 1 fmt", 64'(beat_data[0][31:29]), 64'(is_wr ? FMT_DATA : FMT_NODATA));
    expect_eq("beat 1 type hi", 64'(beat_data[0][28:25]), 64'(TYPE_CFG_HI));
    expect_eq("beat 1 type lo", 64'(beat_data[0][24]), 64'(tx_type[i][0]));
    expect_eq("beat 1 length", 64'(beat_data[0][9:0]), 64'd1);
    expect_eq("beat 1 first_be", 64'(beat_data[0][35:32]),
              64'(is_wr ? tx_wstrb[i][3:0] : 4'hf));
    expect_eq("beat 1 requester_id", 64'(beat_data[0][63:48]), 64'(requester_id));
    expect_eq("beat 1 tstrb", 64'(beat_strb[0]), 64'hff);
    expect_eq("beat 1 tlast", 64'(beat_last[0]), 64'd0);
    if (have_tag) expect_eq("beat 1 tag", 64'(tag), 64'(exp_tag));
    expect_eq("beat 2 bus", 64'(beat_data[1][31:24]), 64'(a[27:20]));
    expect_eq("beat 2 device", 64'(beat_data[1][23:19]), 64'(a[19:15]));
    expect_eq("beat 2 function", 64'(beat_data[1][18:16]), 64'(a[14:12]));
    expect_eq("beat 2 register", 64'(beat_data[1][11:2]), 64'(a[11:2]));
    expect_eq("beat 2 tstrb", 64'(beat_strb[1]), 64'(is_wr ? 8'hff : 8'h0f));
    expect_eq("beat 2 tlast", 64'(beat_last[1]), 64'd1);
    if (is_wr) expect_eq("beat 2 payload", 64'(beat_data[1][63:32]), 64'(tx_data[i]));
    last_tag = tag;
    have_tag = 1'b1;
  endtask

  task automatic wait_rx_accept();
    do @(negedge com_cclk); while (!m_axis_cfg_tready);
    @(posedge com_cclk);
    #1;
  endtask

  task automatic send_cpl(input logic [2:0] tag, input logic [2:0] status,
                          input logic [31:0] payload, input logic has_data);
    logic [31:0] dw0;
    dw0 = {(has_data ? 3'b010 : 3'b000), 5'b01010, 14'd0, 10'd1}; // Cpl or CplD
    m_axis_cfg_tdata  = {16'h0200, status, 1'b0, 12'd4, dw0};   // Completer id, byte count 4
    m_axis_cfg_tstrb  = 8'hff;
    m_axis_cfg_tlast  = 1'b0;
    m_axis_cfg_tvalid = 1'b1;
    wait_rx_accept();
    m_axis_cfg_tdata  = {(has_data ? payload : 32'd0), requester_id, 5'd0, tag, 8'd0};
    m_axis_cfg_tstrb  = has_data ? 8'hff : 8'h0f;
    m_axis_cfg_tlast  = 1'b1;
    wait_rx_accept();
    m_axis_cfg_tvalid = 1'b0;
    m_axis_cfg_tlast  = 1'b0;
  endtask

  task automatic answer_request(input int i);
    logic             has_data;
    logic [TAG_W-1:0] bad_tag;
    has_data = !tx_op[i][0] && (tx_status[i][2:0] == 3'd0);
    bad_tag  = last_tag + 3'd4;
    if (tx_act[i] == 32'd2) begin              // Wrong tag first, must be dropped
      send_cpl(bad_tag, 3'd0, tx_data[i], has_data);
      repeat (6) begin
        @(negedge com_cclk);
        if (s_axi_ctl_bvalid || s_axi_ctl_rvalid) report_error("response to a stale completion");
      end
      @(posedge com_cclk);
      #1;
    end
    if (tx_act[i] != 32'd3) begin
      send_cpl(last_tag, tx_status[i][2:0], tx_data[i], has_data);
    end
  endtask

  task automatic finish_response(input int i);
    int   stall;
    logic is_wr;
    logic timed_out;
    is_wr     = tx_op[i][0];
    timed_out = (tx_act[i] == 32'd3);
    if (i + 1 < n_tx) begin                    // Next request waits behind this one
      present_request(i + 1);
    end
    do @(negedge com_cclk); while (!(is_wr ? s_axi_ctl_bvalid : s_axi_ctl_rvalid));
    stall = $urandom % 4;                      // Hold ready off a little
    repeat (stall) begin
      @(negedge com_cclk);
      if (!(is_wr ? s_axi_ctl_bvalid : s_axi_ctl_rvalid)) report_error("response dropped early");
    end
    @(posedge com_cclk);
    #1;
    s_axi_ctl_bready = is_wr;
    s_axi_ctl_rready = !is_wr;
    @(negedge com_cclk);
    if (is_wr) begin
      expect_eq("s_axi_ctl_bresp", 64'(s_axi_ctl_bresp), 64'(tx_resp[i][1:0]));
    end else begin
      expect_eq("s_axi_ctl_rresp", 64'(s_axi_ctl_rresp), 64'(tx_resp[i][1:0]));
      expect_eq("s_axi_ctl_rdata", 64'(s_axi_ctl_rdata), 64'(tx_rdata[i]));
    end
    expect_eq("cpl_status", 64'(cpl_status), 64'(timed_out ? 3'd0 : tx_status[i][2:0]));
    expect_eq("cfg_timeout", 64'(cfg_timeout), 64'(timed_out));
    @(posedge com_cclk);
    #1;
    s_axi_ctl_bready = 1'b0;
    s_axi_ctl_rready = 1'b0;
    if (s_axi_ctl_bvalid || s_axi_ctl_rvalid) report_error("response still valid after handshake");
    expect_eq("cfg_timeout after handshake", 64'(cfg_timeout), 64'd0);
  endtask

  // Stalled beats must hold
  always @(negedge com_cclk) begin
    if (!com_sysrst && stalled) begin
      if (!s_axis_cfg_tvalid) begin
        stream_errors++;
        $display("error at %0t: tvalid fell before the beat was accepted", $time);
      end
      if ({s_axis_cfg_tdata, s_axis_cfg_tstrb, s_axis_cfg_tlast} !==
          {held_data, held_strb, held_last}) begin
        stream_errors++;
        $display("mismatch at %0t: s_axis_cfg_tdata/tstrb/tlast got %h %h %b expected %h %h %b",
                 $time, s_axis_cfg_tdata, s_axis_cfg_tstrb, s_axis_cfg_tlast,
                 held_data, held_strb, held_last);
      end
    end
    stalled   = s_axis_cfg_tvalid && !s_axis_cfg_tready;
    held_data = s_axis_cfg_tdata;
    held_strb = s_axis_cfg_tstrb;
    held_last = s_axis_cfg_tlast;
  end

  // One open request at a time
  always @(negedge com_cclk) begin
    if (!com_sysrst) begin
      if ((s_axi_ctl_bvalid && s_axi_ctl_bready) || (s_axi_ctl_rvalid && s_axi_ctl_rready)) begin
        req_open = 1'b0;
      end
      if (s_axi_ctl_awready || s_axi_ctl_arready) begin
        if (req_open) begin
          request_errors++;
          $display("error at %0t: new request accepted before the response handshake", $time);
        end
        req_open = 1'b1;
      end
    end
  end

  initial begin
    @(negedge com_sysrst);                     // Table is loaded by now
    wd_limit = n_tx * (CPL_TIMEOUT_CYCLES + 100) * 8 + 16 * 8; // Worst case per line
    #(wd_limit);
    $display("watchdog expired before all transactions finished");
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    void'($urandom(54));
    com_sysrst        = 1'b1;
    s_axi_ctl_awaddr  = '0;
    s_axi_ctl_awvalid = 1'b0;
    s_axi_ctl_wdata   = '0;
    s_axi_ctl_wstrb   = '0;
    s_axi_ctl_wvalid  = 1'b0;
    s_axi_ctl_bready  = 1'b0;
    s_axi_ctl_araddr  = '0;
    s_axi_ctl_arvalid = 1'b0;
    s_axi_ctl_rready  = 1'b0;
    m_axis_cfg_tdata  = '0;
    m_axis_cfg_tvalid = 1'b0;
    m_axis_cfg_tstrb  = '0;
    m_axis_cfg_tlast  = 1'b0;
    requester_id      = 16'h01a0;              // Root port bus 1 dev 20
    cfg_type          = 1'b0;
    last_tag          = '0;
    load_stimulus();
    if (!load_ok || n_tx == 0) begin
      $display("could not read any transaction from bench/cfg_stimulus.txt");
      $display("TEST FAIL");
      $finish;
    end else begin
      repeat (16) @(posedge com_cclk);
      #1;
      com_sysrst = 1'b0;
      for (int i = 0; i < n_tx; i++) begin
        cfg_type = tx_type[i][0];
        issue_request(i);
        capture_beats();
        check_beats(i);
        answer_request(i);
        finish_response(i);
      end
      repeat (4) @(posedge com_cclk);
      $display("errors: %0d (checks %0d, stream hold %0d, request overlap %0d)",
               errors + stream_errors + request_errors, errors, stream_errors, request_errors);
      if (errors + stream_errors + request_errors == 0) begin
        $display("TEST PASS");
      end else begin
        $display("TEST FAIL");
      end
      $finish;
    end
  end

endmodule

/* bench/cfg_stimulus.txt */
# op(0 rd,1 wr) cfg_type addr wdata wstrb action(0 ok,1 bad_status,2 stale_tag,3 none) status
# cpl_data(wire order, beat 2 payload for writes) exp_resp exp_rdata, all hex
0 0 00111010 00000000 0 0 0 11223344 0 44332211
1 0 00111014 a5b6c7d8 f 0 0 d8c7b6a5 0 00000000
1 1 0ff7f0fc 01020304 3 0 0 04030201 0 00000000
0 1 02308004 00000000 0 1 1 00000000 2 00000000
0 0 00000000 00000000 0 2 0 deadbeef 0 efbeadde
0 0 00a4a100 00000000 0 3 0 00000000 2 00000000
1 0 00a4a100 12345678 c 0 0 78563412 0 00000000
1 0 00200040 cafef00d f 1 4 0df0feca 2 00000000
0 1 0fffffff 00000000 0 0 0 89abcdef 0 efcdab89
1 1 00308008 55aa00ff 1 2 0 ff00aa55 0 00000000
1 0 00010000 00000000 f 3 0 00000000 2 00000000
0 0 00108ffc 00000000 0 1 2 00000000 2 00000000
0 0 00509000 00000000 0 0 0 00000001 0 01000000
1 0 00150020 0badcafe 6 0 0 fecaad0b 0 00000000

/* sim.f */
hw/cfg_pkg.sv
hw/cfg_req_if.sv
hw/cfg_axil_slave.sv
hw/cfg_tlp_builder.sv
hw/cfg_cpl_parser.sv
hw/cfg_cpl_timer.sv
hw/cfg_bridge_top.sv
bench/tb_cfg_bridge.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cfg_bridge -f sim.f -o tb_sim \
  && out="$(./obj_dir/tb_sim)" \
  && echo "$out" \
  && grep -qx "TEST PASS" <<< "$out" \
  || { echo "simulation failed"; exit 1; }
